// File: Makefile
# Verilator build and run of the flash boot loader testbench

TOP  = tb_flash_boot
SRCS = $(filter %.sv,$(shell cat verilog.f))

obj_dir/V$(TOP): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: boot_stream_decode.sv
/* boot stream decoder
   clears both RAMs, then turns flash stream bytes into RAM writes */

`timescale 1ns/100ps

module boot_stream_decode #(
  parameter int CODE_SIZE = 10,
  parameter int WIDTH     = 18
) (
  input  logic             clk,
  input  logic             arstn,
  input  logic             i_byte_stb,
  input  logic [7:0]       i_f_din,
  output logic             o_clear_busy,
  output logic             o_end_stb,
  output logic             o_p_reset,
  output logic [3:0]       o_f_rate,
  output logic             o_code_wr,
  output logic             o_data_wr,
  output logic [15:0]      o_dest,
  output logic [WIDTH-1:0] o_word
);

  import flash_boot_pkg::*;

  boot_mode_e           mode;
  stream_op_e           op;
  logic [CODE_SIZE-1:0] clr_count;  // words left to clear
  logic [15:0]          length;     // words in run minus one
  logic [1:0]           bytes;      // bytes per word minus one
  logic [1:0]           byte_cnt;
  logic                 bump_dest;

  assign op = stream_op_e'(i_f_din[7:6]);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_clear_busy <= 1'b1;
      clr_count    <= '1;
      mode         <= MODE_CMD;
      length       <= 16'd0;
      bytes        <= 2'd0;
      byte_cnt     <= 2'd0;
      o_dest       <= 16'd0;
      o_word       <= '0;  // zero is what the clear phase writes
      o_code_wr    <= 1'b0;
      o_data_wr    <= 1'b0;
      bump_dest    <= 1'b0;
      o_end_stb    <= 1'b0;
      o_p_reset    <= 1'b1;
      o_f_rate     <= RATE_POR;
    end else begin
      o_code_wr <= 1'b0;  // strobes
      o_data_wr <= 1'b0;
      bump_dest <= 1'b0;
      o_end_stb <= 1'b0;
      if (bump_dest) begin
        o_dest <= o_dest + 16'd1;  // one cycle after the write
      end

      // ==============================
      // RAM clear
      // ==============================
      if (o_clear_busy) begin
        o_code_wr <= 1'b1;
        o_data_wr <= 1'b1;
        bump_dest <= 1'b1;
        if (clr_count != '0) begin
          clr_count <= clr_count - 1'b1;
        end else begin
          o_clear_busy <= 1'b0;
        end

      // ==============================
      // stream interpreter
      // ==============================
      end else if (i_byte_stb) begin
        case (mode)
          MODE_CMD: begin
            case (op)
              OP_CTRL: begin
                if (i_f_din[5]) begin
                  o_end_stb <= 1'b1;
                  o_p_reset <= i_f_din[4];
                end else begin
                  case (i_f_din[1:0])
                    2'b01:   mode <= MODE_DEST_HI;
                    2'b00:   mode <= MODE_DEST_LO;
                    2'b11:   mode <= MODE_LEN_HI;
                    default: mode <= MODE_LEN_LO;
                  endcase
                end
              end
              OP_RATE: o_f_rate <= i_f_din[3:0];
              default: begin  // data run
                mode     <= i_f_din[2] ? MODE_DATA_WR : MODE_CODE_WR;
                bytes    <= i_f_din[1:0];
                byte_cnt <= i_f_din[1:0];
              end
            endcase
          end
          MODE_CODE_WR, MODE_DATA_WR: begin
            o_word <= {o_word[WIDTH-9:0], i_f_din};  // high byte first
            if (byte_cnt != 2'd0) begin
              byte_cnt <= byte_cnt - 2'd1;
            end else begin
              byte_cnt  <= bytes;
              o_code_wr <= (mode == MODE_CODE_WR);
              o_data_wr <= (mode == MODE_DATA_WR);
              bump_dest <= 1'b1;
              if (length != 16'd0) begin
                length <= length - 16'd1;
              end else begin
                mode <= MODE_CMD;  // run done
              end
            end
          end
          MODE_DEST_HI: begin
            o_dest[15:8] <= i_f_din;
            mode         <= MODE_DEST_LO;
          end
          MODE_DEST_LO: begin
            o_dest[7:0] <= i_f_din;
            mode        <= MODE_CMD;
          end
          MODE_LEN_HI: begin
            length[15:8] <= i_f_din;
            mode         <= MODE_LEN_LO;
          end
          MODE_LEN_LO: begin
            length[7:0] <= i_f_din;
            mode        <= MODE_CMD;
          end
          default: mode <= MODE_CMD;
        endcase
      end
    end
  end

endmodule

// File: flash_boot_assertions.sv
/* flash boot loader port checks
   transfer strobe shape and flash release after boot */

`timescale 1ns/100ps

module flash_boot_assertions (
  input logic       clk,
  input logic       arstn,
  input logic       i_f_ready,
  input logic       i_f_wr,
  input logic [2:0] i_f_format,
  input logic       i_booting
);

  import flash_boot_pkg::*;

  // ==============================
  // transfer strobe
  // ==============================
  property wr_single_cycle;
    @(posedge clk) disable iff (!arstn)
      i_f_wr |=> !i_f_wr;
  endproperty

  property wr_needs_ready;
    @(posedge clk) disable iff (!arstn)
      $rose(i_f_wr) |-> $past(i_f_ready);  // ready seen when the pulse was issued
  endproperty

  // chip select stays released once boot ends
  property off_after_boot;
    @(posedge clk) disable iff (!arstn)
      !i_booting |-> (i_f_format == FMT_OFF);
  endproperty

  a_wr_single_cycle: assert property (wr_single_cycle)
    else $error("o_f_wr stayed high for two cycles");
  a_wr_needs_ready: assert property (wr_needs_ready)
    else $error("o_f_wr rose while i_f_ready was low");
  a_off_after_boot: assert property (off_after_boot)
    else $error("o_f_format not released after boot");

endmodule

bind flash_boot_top flash_boot_assertions u_assertions (
  .clk        (clk),
  .arstn      (arstn),
  .i_f_ready  (i_f_ready),
  .i_f_wr     (o_f_wr),
  .i_f_format (o_f_format),
  .i_booting  (o_booting)
);

// File: flash_boot_pkg.sv
/* flash boot loader shared definitions
   FSM states, stream opcodes, flash command constants and I/O addresses */

package flash_boot_pkg;

  // ==============================
  // flash fetch sequencer states
  // ==============================
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,  // boot finished, flash released
    ST_CMD      = 3'd1,  // send read opcode
    ST_ADDR_HI  = 3'd2,  // sector byte
    ST_ADDR_MID = 3'd3,
    ST_ADDR_LO  = 3'd4,
    ST_DUMMY    = 3'd5,  // fast-read dummy byte
    ST_STREAM   = 3'd6   // continuous read of the boot stream
  } boot_state_e;

  // ==============================
  // boot stream interpreter modes
  // ==============================
  typedef enum logic [2:0] {
    MODE_CMD      = 3'd0,  // next byte is a command
    MODE_CODE_WR  = 3'd1,  // bytes build code words
    MODE_DATA_WR  = 3'd2,  // bytes build data words
    MODE_DEST_LO  = 3'd3,
    MODE_DEST_HI  = 3'd4,
    MODE_LEN_LO   = 3'd5,
    MODE_LEN_HI   = 3'd6
  } boot_mode_e;

  // top two bits of a command byte
  typedef enum logic [1:0] {
    OP_DATA0 = 2'b00,
    OP_DATA1 = 2'b01,
    OP_RATE  = 2'b10,  // set SCLK divisor
    OP_CTRL  = 2'b11   // address, length or end
  } stream_op_e;

  localparam logic [7:0] FAST_READ_CMD = 8'h0B;
  localparam logic [2:0] FMT_OFF       = 3'd0;  // CS# high
  localparam logic [2:0] FMT_STREAM    = 3'd2;  // CS# held low between bytes
  localparam logic [3:0] RATE_POR      = 4'h7;  // SCLK divisor out of reset

  localparam logic [2:0] IO_ADDR_FLASH   = 3'd3;
  localparam logic [2:0] IO_ADDR_BOOTING = 3'd5;

endpackage

// File: flash_boot_top.sv
/* serial flash boot loader for a stack processor
   loads code and data RAM from an SPI flash stream, then runs the processor */

`timescale 1ns/100ps

module flash_boot_top #(
  parameter int         CODE_SIZE = 10,     // log2 code RAM depth
  parameter int         DATA_SIZE = 10,     // log2 data RAM depth
  parameter int         WIDTH     = 18,     // data word size
  parameter logic [7:0] BASEBLOCK = 8'h04   // flash sector of the boot image
) (
  input  logic             clk,
  input  logic             arstn,
  // processor side
  input  logic             i_mem_rd,
  input  logic             i_mem_wr,
  input  logic [14:0]      i_mem_addr,
  input  logic [WIDTH-1:0] i_din,
  output logic [WIDTH-1:0] o_mem_dout,
  input  logic [14:0]      i_code_addr,
  output logic [15:0]      o_insn,
  output logic [WIDTH-1:0] o_io_dout,
  output logic             o_p_hold,
  output logic             o_p_reset,
  output logic             o_booting,
  // flash side
  input  logic             i_f_ready,
  input  logic [7:0]       i_f_din,
  output logic             o_f_wr,
  output logic [7:0]       o_f_dout,
  output logic [2:0]       o_f_format,
  output logic [3:0]       o_f_rate
);

  import flash_boot_pkg::*;

  logic             clear_busy;
  logic             end_stb;
  logic             byte_stb;
  logic             format_stream;
  logic             code_wr;
  logic             data_wr;
  logic [15:0]      dest;
  logic [WIDTH-1:0] word;

  assign o_f_format = format_stream ? FMT_STREAM : FMT_OFF;

  flash_fetch_seq #(
    .BASEBLOCK (BASEBLOCK)
  ) u_fetch (
    .clk             (clk),
    .arstn           (arstn),
    .i_f_ready       (i_f_ready),
    .i_clear_busy    (clear_busy),
    .i_end_stb       (end_stb),
    .o_f_wr          (o_f_wr),
    .o_f_dout        (o_f_dout),
    .o_format_stream (format_stream),
    .o_byte_stb      (byte_stb),
    .o_booting       (o_booting)
  );

  boot_stream_decode #(
    .CODE_SIZE (CODE_SIZE),
    .WIDTH     (WIDTH)
  ) u_decode (
    .clk          (clk),
    .arstn        (arstn),
    .i_byte_stb   (byte_stb),
    .i_f_din      (i_f_din),
    .o_clear_busy (clear_busy),
    .o_end_stb    (end_stb),
    .o_p_reset    (o_p_reset),
    .o_f_rate     (o_f_rate),
    .o_code_wr    (code_wr),
    .o_data_wr    (data_wr),
    .o_dest       (dest),
    .o_word       (word)
  );

  mem_port_arbiter #(
    .CODE_SIZE (CODE_SIZE),
    .DATA_SIZE (DATA_SIZE),
    .WIDTH     (WIDTH)
  ) u_arbiter (
    .clk         (clk),
    .i_code_wr   (code_wr),
    .i_data_wr   (data_wr),
    .i_dest      (dest),
    .i_word      (word),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),
    .i_din       (i_din),
    .i_code_addr (i_code_addr),
    .i_f_din     (i_f_din),
    .i_booting   (o_booting),
    .o_mem_dout  (o_mem_dout),
    .o_insn      (o_insn),
    .o_p_hold    (o_p_hold),
    .o_io_dout   (o_io_dout)
  );

endmodule

// File: flash_fetch_seq.sv
/* flash fetch sequencer
   sends the fast-read header, then pulls stream bytes for the decoder */

`timescale 1ns/100ps

module flash_fetch_seq #(
  parameter logic [7:0] BASEBLOCK = 8'h00
) (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_f_ready,
  input  logic       i_clear_busy,
  input  logic       i_end_stb,
  output logic       o_f_wr,
  output logic [7:0] o_f_dout,
  output logic       o_format_stream,
  output logic       o_byte_stb,
  output logic       o_booting
);

  import flash_boot_pkg::*;

  boot_state_e state;
  logic        f_ok;  // a new transfer may start

  // one pulse per transfer, never back to back
  assign f_ok      = i_f_ready & ~o_f_wr & ~i_clear_busy;
  assign o_booting = (state != ST_IDLE);

  // ==============================
  // header and stream transfers
  // ==============================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state           <= ST_CMD;
      o_f_wr          <= 1'b0;
      o_f_dout        <= 8'h00;
      o_format_stream <= 1'b0;
      o_byte_stb      <= 1'b0;
    end else begin
      o_f_wr     <= 1'b0;  // strobes
      o_byte_stb <= 1'b0;
      if (i_end_stb) begin
        state           <= ST_IDLE;  // release the flash
        o_format_stream <= 1'b0;
      end else if (f_ok && state != ST_IDLE) begin
        o_f_wr          <= 1'b1;
        o_format_stream <= 1'b1;
        case (state)
          ST_CMD: begin
            o_f_dout <= FAST_READ_CMD;
            state    <= ST_ADDR_HI;
          end
          ST_ADDR_HI: begin
            o_f_dout <= BASEBLOCK;  // 64KB sector
            state    <= ST_ADDR_MID;
          end
          ST_ADDR_MID: begin
            o_f_dout <= 8'h00;
            state    <= ST_ADDR_LO;
          end
          ST_ADDR_LO: begin
            o_f_dout <= 8'h00;
            state    <= ST_DUMMY;
          end
          ST_DUMMY: begin
            o_f_dout <= 8'h00;
            state    <= ST_STREAM;
          end
          ST_STREAM: begin
            // each transfer hands the byte already received to the decoder
            o_f_dout   <= 8'h00;
            o_byte_stb <= 1'b1;
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

endmodule

// File: mem_port_arbiter.sv
/* RAM port arbiter
   boot writes take the RAM ports and hold the processor, plus the I/O read mux */

`timescale 1ns/100ps

module mem_port_arbiter #(
  parameter int CODE_SIZE = 10,
  parameter int DATA_SIZE = 10,
  parameter int WIDTH     = 18
) (
  input  logic             clk,
  input  logic             i_code_wr,
  input  logic             i_data_wr,
  input  logic [15:0]      i_dest,
  input  logic [WIDTH-1:0] i_word,
  input  logic             i_mem_rd,
  input  logic             i_mem_wr,
  input  logic [14:0]      i_mem_addr,
  input  logic [WIDTH-1:0] i_din,
  input  logic [14:0]      i_code_addr,
  input  logic [7:0]       i_f_din,
  input  logic             i_booting,
  output logic [WIDTH-1:0] o_mem_dout,
  output logic [15:0]      o_insn,
  output logic             o_p_hold,
  output logic [WIDTH-1:0] o_io_dout
);

  import flash_boot_pkg::*;

  logic [CODE_SIZE-1:0] code_addr;
  logic                 code_re;
  logic [DATA_SIZE-1:0] data_addr;
  logic [WIDTH-1:0]     data_din;
  logic                 data_we;
  logic                 data_re;

  assign o_p_hold = i_code_wr | i_data_wr;  // boot owns the RAMs this cycle

  assign code_addr = i_code_wr ? i_dest[CODE_SIZE-1:0] : i_code_addr[CODE_SIZE-1:0];
  assign code_re   = ~o_p_hold;

  assign data_addr = i_data_wr ? i_dest[DATA_SIZE-1:0] : i_mem_addr[DATA_SIZE-1:0];
  assign data_din  = i_data_wr ? i_word : i_din;
  assign data_we   = i_mem_wr | i_data_wr;
  assign data_re   = i_mem_rd & ~o_p_hold;

  // ==============================
  // I/O read space
  // ==============================
  always_comb begin
    case (i_mem_addr[2:0])
      IO_ADDR_FLASH:   o_io_dout = {{(WIDTH-8){1'b0}}, i_f_din};  // last SPI byte
      IO_ADDR_BOOTING: o_io_dout = {{(WIDTH-1){1'b0}}, i_booting};
      default:         o_io_dout = '0;
    endcase
  end

  spram #(
    .ADDR_WIDTH (DATA_SIZE),
    .DATA_WIDTH (WIDTH)
  ) data_ram (
    .clk    (clk),
    .i_addr (data_addr),
    .i_din  (data_din),
    .i_we   (data_we),
    .i_re   (data_re),
    .o_dout (o_mem_dout)
  );

  spram #(
    .ADDR_WIDTH (CODE_SIZE),
    .DATA_WIDTH (16)
  ) code_ram (
    .clk    (clk),
    .i_addr (code_addr),
    .i_din  (i_word[15:0]),  // code words are 16 bits
    .i_we   (i_code_wr),
    .i_re   (code_re),
    .o_dout (o_insn)
  );

endmodule

// File: spram.sv
/* single-port RAM, synchronous write and registered read */

`timescale 1ns/100ps

module spram #(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 18
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_din,
  input  logic                  i_we,
  input  logic                  i_re,
  output logic [DATA_WIDTH-1:0] o_dout
);

  logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_din;
    end
    if (i_re) begin
      o_dout <= mem[i_addr];  // data valid the cycle after i_re
    end
  end

endmodule

// File: tb_flash_boot.sv
/* flash boot loader testbench
   flash model, boot image with its reference walk, and processor-side read-back */

`timescale 1ns/100ps

module tb_flash_boot;

  import flash_boot_pkg::*;

  localparam int         CODE_SIZE    = 10;
  localparam int         DATA_SIZE    = 10;
  localparam int         WIDTH        = 18;
  localparam logic [7:0] BASEBLOCK    = 8'h04;
  localparam int         MAX_IMAGE    = 128;
  localparam int         BOOT_TIMEOUT = 20000;  // cycles
  localparam int         NUM_WRITES   = 32;

  logic             clk;
  logic             arstn;
  logic             mem_rd;
  logic             mem_wr;
  logic [14:0]      mem_addr;
  logic [WIDTH-1:0] din;
  logic [WIDTH-1:0] mem_dout;
  logic [14:0]      code_addr;
  logic [15:0]      insn;
  logic [WIDTH-1:0] io_dout;
  logic             p_hold;
  logic             p_reset;
  logic             booting;
  logic             f_ready;
  logic [7:0]       f_din;
  logic             f_wr;
  logic [7:0]       f_dout;
  logic [2:0]       f_format;
  logic [3:0]       f_rate;

  logic [7:0]       image [0:MAX_IMAGE-1];
  logic [3:0]       exp_rate [0:MAX_IMAGE-1];  // rate after each image byte
  logic [15:0]      exp_code [0:(1<<CODE_SIZE)-1];
  logic [WIDTH-1:0] exp_data [0:(1<<DATA_SIZE)-1];
  logic             exp_p_reset;
  int               image_len;
  int               end_index;
  int               xfer_count;
  int               err_count;
  int               fail_count;
  integer           seed;

  flash_boot_top #(
    .CODE_SIZE (CODE_SIZE),
    .DATA_SIZE (DATA_SIZE),
    .WIDTH     (WIDTH),
    .BASEBLOCK (BASEBLOCK)
  ) u_dut (
    .clk         (clk),
    .arstn       (arstn),
    .i_mem_rd    (mem_rd),
    .i_mem_wr    (mem_wr),
    .i_mem_addr  (mem_addr),
    .i_din       (din),
    .o_mem_dout  (mem_dout),
    .i_code_addr (code_addr),
    .o_insn      (insn),
    .o_io_dout   (io_dout),
    .o_p_hold    (p_hold),
    .o_p_reset   (p_reset),
    .o_booting   (booting),
    .i_f_ready   (f_ready),
    .i_f_din     (f_din),
    .o_f_wr      (f_wr),
    .o_f_dout    (f_dout),
    .o_f_format  (f_format),
    .o_f_rate    (f_rate)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
    err_count++;
  endtask

  // ==============================
  // boot image
  // ==============================
  task automatic add_byte(input logic [7:0] b);
    image[image_len] = b;
    image_len++;
  endtask

  task automatic put_dest(input logic [15:0] dest);
    add_byte(8'hC1);  // destination high, then low
    add_byte(dest[15:8]);
    add_byte(dest[7:0]);
  endtask

  task automatic put_len_low(input logic [7:0] len);
    add_byte(8'hC2);
    add_byte(len);
  endtask

  task automatic put_run(input logic [7:0] cmd, input int words);
    int n;
    n = words * (int'(cmd[1:0]) + 1);
    add_byte(cmd);
    repeat (n) add_byte(8'($random(seed)));  // random payload
  endtask

  task automatic build_image();
    image_len = 0;
    add_byte(8'h83);  // rate 3
    put_dest(16'h0120);
    add_byte(8'hC3);  // length high, then low
    add_byte(8'h00);
    add_byte(8'h07);
    put_run(8'h01, 8);  // code, 2 bytes per word
    add_byte(8'h85);
    add_byte(8'hC0);  // destination low only
    add_byte(8'h40);
    put_len_low(8'd5);
    put_run(8'h06, 6);  // data, 3 bytes per word
    put_dest(16'h03FE);
    put_len_low(8'd3);
    put_run(8'h41, 4);  // code run past the top of the RAM
    add_byte(8'hC0);
    add_byte(8'h80);
    put_len_low(8'd2);
    put_run(8'h04, 3);  // data, 1 byte per word
    add_byte(8'h81);
    add_byte(8'hE0);  // end, processor out of reset
  endtask

  // walks the image by the stream rules, unwritten words stay zero
  function automatic void build_reference();
    boot_mode_e       mode;
    logic [15:0]      dest;
    logic [15:0]      len;
    logic [1:0]       nbytes;
    logic [1:0]       left;
    logic [WIDTH-1:0] word;
    logic [3:0]       rate;
    logic [7:0]       b;
    int               i;
    mode        = MODE_CMD;
    dest        = 16'd0;
    len         = 16'd0;
    nbytes      = 2'd0;
    left        = 2'd0;
    word        = '0;
    rate        = RATE_POR;
    end_index   = -1;
    exp_p_reset = 1'b1;
    for (i = 0; i < (1 << CODE_SIZE); i++) exp_code[i] = '0;
    for (i = 0; i < (1 << DATA_SIZE); i++) exp_data[i] = '0;
    for (i = 0; i < image_len && end_index < 0; i++) begin
      b = image[i];
      case (mode)
        MODE_CMD: begin
          if (b[7:6] == 2'b11 && b[5]) begin
            end_index   = i;
            exp_p_reset = b[4];
          end else if (b[7:6] == 2'b11) begin
            case (b[1:0])
              2'b00:   mode = MODE_DEST_LO;
              2'b01:   mode = MODE_DEST_HI;
              2'b10:   mode = MODE_LEN_LO;
              default: mode = MODE_LEN_HI;
            endcase
          end else if (b[7:6] == 2'b10) begin
            rate = b[3:0];
          end else begin
            mode   = b[2] ? MODE_DATA_WR : MODE_CODE_WR;
            nbytes = b[1:0];
            left   = b[1:0];
          end
        end
        MODE_CODE_WR, MODE_DATA_WR: begin
          word = (word << 8) | WIDTH'(b);  // high byte first
          if (left != 2'd0) begin
            left = left - 2'd1;
          end else begin
            left = nbytes;
            if (mode == MODE_CODE_WR) exp_code[dest[CODE_SIZE-1:0]] = word[15:0];
            else exp_data[dest[DATA_SIZE-1:0]] = word;
            dest = dest + 16'd1;
            if (len != 16'd0) len = len - 16'd1;
            else mode = MODE_CMD;
          end
        end
        MODE_DEST_HI: begin
          dest[15:8] = b;
          mode       = MODE_DEST_LO;
        end
        MODE_DEST_LO: begin
          dest[7:0] = b;
          mode      = MODE_CMD;
        end
        MODE_LEN_HI: begin
          len[15:8] = b;
          mode      = MODE_LEN_LO;
        end
        default: begin
          len[7:0] = b;
          mode     = MODE_CMD;
        end
      endcase
      exp_rate[i] = rate;
    end
  endfunction

  // ==============================
  // flash model
  // ==============================
  function automatic logic [7:0] header_byte(input int t);
    if (t == 1) return FAST_READ_CMD;
    if (t == 2) return BASEBLOCK;
    return 8'h00;
  endfunction

  function automatic logic [7:0] next_flash_byte(input int t);
    if (t >= 5 && t - 5 < image_len) return image[t-5];  // stream starts after header
    return 8'hFF;
  endfunction

  initial begin
    int delay;
    forever begin
      @(negedge clk);
      if (f_wr) begin
        xfer_count++;
        if (f_format !== FMT_STREAM) report_mismatch("o_f_format", f_format, FMT_STREAM);
        if (xfer_count <= 5) begin
          if (f_dout !== header_byte(xfer_count)) begin
            report_mismatch("o_f_dout", f_dout, header_byte(xfer_count));
          end
        end else if (xfer_count == 6) begin
          if (f_rate !== RATE_POR) report_mismatch("o_f_rate", f_rate, RATE_POR);
        end else if (xfer_count - 7 < image_len) begin
          if (f_rate !== exp_rate[xfer_count-7]) begin
            report_mismatch("o_f_rate", f_rate, exp_rate[xfer_count-7]);
          end
        end
        delay = 2 + int'($unsigned($random(seed)) % 5);  // busy 2 to 6 cycles
        @(posedge clk);
        f_ready <= 1'b0;
        repeat (delay) @(posedge clk);
        f_din   <= next_flash_byte(xfer_count);
        f_ready <= 1'b1;
      end
    end
  end

  // ==============================
  // reset and boot
  // ==============================
  task automatic reset_and_boot(output logic done);
    int k;
    @(posedge clk);
    arstn    <= 1'b0;
    mem_rd   <= 1'b0;
    mem_addr <= 15'(IO_ADDR_BOOTING);
    xfer_count = 0;
    @(posedge clk);
    @(negedge clk);
    if (p_reset !== 1'b1) report_mismatch("o_p_reset", p_reset, 1'b1);
    if (f_wr !== 1'b0) report_mismatch("o_f_wr", f_wr, 1'b0);
    @(posedge clk);
    arstn <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);  // RAM clear running
    if (p_reset !== 1'b1) report_mismatch("o_p_reset", p_reset, 1'b1);
    if (p_hold !== 1'b1) report_mismatch("o_p_hold", p_hold, 1'b1);
    if (f_wr !== 1'b0) report_mismatch("o_f_wr", f_wr, 1'b0);
    if (booting !== 1'b1) report_mismatch("o_booting", booting, 1'b1);
    if (io_dout !== WIDTH'(1)) report_mismatch("o_io_dout booting", io_dout, 1);

    k = 0;
    while (booting && k < BOOT_TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    done = !booting;
    if (!done) begin
      $display("timeout: boot did not finish within %0d cycles", BOOT_TIMEOUT);
      fail_count++;
    end
  endtask

  // ==============================
  // processor side checks
  // ==============================
  task automatic check_boot_end();
    repeat (8) @(negedge clk);  // longer than any flash busy time
    if (xfer_count != end_index + 6) report_mismatch("transfer count", xfer_count, end_index + 6);
    if (p_reset !== exp_p_reset) report_mismatch("o_p_reset", p_reset, exp_p_reset);
    if (p_hold !== 1'b0) report_mismatch("o_p_hold", p_hold, 1'b0);
    if (f_format !== FMT_OFF) report_mismatch("o_f_format", f_format, FMT_OFF);
    if (io_dout !== '0) report_mismatch("o_io_dout booting", io_dout, 0);
    @(posedge clk);
    mem_addr <= 15'(IO_ADDR_FLASH);
    @(negedge clk);
    if (io_dout !== WIDTH'(f_din)) report_mismatch("o_io_dout flash", io_dout, f_din);
  endtask

  task automatic read_back_rams();
    int a;
    for (a = 0; a < (1 << CODE_SIZE); a++) begin
      @(posedge clk);
      code_addr <= 15'(a);
      @(posedge clk);
      @(negedge clk);  // registered read
      if (insn !== exp_code[a]) report_mismatch($sformatf("o_insn[%0d]", a), insn, exp_code[a]);
    end
    for (a = 0; a < (1 << DATA_SIZE); a++) begin
      @(posedge clk);
      mem_addr <= 15'(a);
      mem_rd   <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      if (mem_dout !== exp_data[a]) begin
        report_mismatch($sformatf("o_mem_dout[%0d]", a), mem_dout, exp_data[a]);
      end
    end
  endtask

  task automatic write_read_data();
    logic [DATA_SIZE-1:0] wr_addr [0:NUM_WRITES-1];
    logic [WIDTH-1:0]     wr_word;
    int                   k;
    for (k = 0; k < NUM_WRITES; k++) begin
      wr_addr[k]           = DATA_SIZE'($random(seed));
      wr_word              = WIDTH'($random(seed));
      exp_data[wr_addr[k]] = wr_word;  // last write to an address wins
      @(posedge clk);
      mem_rd   <= 1'b0;
      mem_wr   <= 1'b1;
      mem_addr <= 15'(wr_addr[k]);
      din      <= wr_word;
    end
    @(posedge clk);
    mem_wr <= 1'b0;
    for (k = 0; k < NUM_WRITES; k++) begin
      @(posedge clk);
      mem_addr <= 15'(wr_addr[k]);
      mem_rd   <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      if (mem_dout !== exp_data[wr_addr[k]]) begin
        report_mismatch($sformatf("o_mem_dout[%0d]", wr_addr[k]), mem_dout, exp_data[wr_addr[k]]);
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    logic booted;
    seed       = 32'h588f_5a32;
    err_count  = 0;
    fail_count = 0;
    xfer_count = 0;
    arstn      = 1'b0;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    mem_addr   = 15'(IO_ADDR_BOOTING);
    din        = '0;
    code_addr  = '0;
    f_ready    = 1'b1;
    f_din      = 8'hFF;
    build_image();
    build_reference();

    reset_and_boot(booted);
    if (booted) begin
      check_boot_end();
      read_back_rams();
      write_read_data();

      // second boot over filled RAMs, the stream is only an end that holds the processor
      image_len = 0;
      add_byte(8'hF0);
      build_reference();
      reset_and_boot(booted);
      if (booted) begin
        check_boot_end();
        read_back_rams();
      end
    end

    $display("checks done: %0d value errors, %0d other errors", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
flash_boot_pkg.sv
spram.sv
flash_fetch_seq.sv
boot_stream_decode.sv
mem_port_arbiter.sv
flash_boot_top.sv
flash_boot_assertions.sv
tb_flash_boot.sv
